//--- verilog/cache_pkg.sv
package cache_pkg;

  // sizes
  localparam int ADDR_W      = 32;
  localparam int WORD_W      = 32;
  localparam int LINE_W      = 128;
  localparam int NUM_SETS    = 16;
  localparam int NUM_WAYS    = 2;
  localparam int WAY_W       = $clog2(NUM_WAYS);

  // address split into tag, index, word offset and byte
  localparam int OFF_W       = 2;
  localparam int IDX_W       = 4;
  localparam int TAG_W       = 24;
  localparam int OFF_LSB     = 2;
  localparam int IDX_LSB     = OFF_LSB + OFF_W;
  localparam int TAG_LSB     = IDX_LSB + IDX_W;
  localparam int LINE_ADDR_W = TAG_W + IDX_W;

  // backing memory
  localparam int MEM_LINES   = 256;
  localparam int MEM_IDX_W   = $clog2(MEM_LINES);
  localparam int MEM_LATENCY = 4;
  localparam int LAT_W       = $clog2(MEM_LATENCY + 1);

  typedef logic [WAY_W-1:0]  way_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [LINE_W-1:0] line_t;

  typedef struct packed {
    logic  valid;
    logic  dirty;
    tag_t  tag;
    line_t data;
  } way_line_t;

  // wishbone classic cpu side
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [WORD_W-1:0] dat;
  } cpu_req_t;

  typedef struct packed {
    logic              ack;
    logic              hit;
    logic [WORD_W-1:0] dat;
  } cpu_rsp_t;

  // memory side moves one full line per transfer
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [LINE_ADDR_W-1:0] adr;
    line_t                  dat;
  } mem_req_t;

  typedef struct packed {
    logic  ack;
    line_t dat;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    st_idle,
    st_compare_tag,
    st_write_back,
    st_allocate
  } ctrl_state_t;

endpackage

//--- verilog/cache_way.sv
`timescale 1ns/10ps

module cache_way (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::idx_t       idx,
  input  cache_pkg::tag_t       tag,
  input  logic                  we,
  input  cache_pkg::way_line_t  wr_line,
  output cache_pkg::way_line_t  rd_line,
  output logic                  hit
);

  import cache_pkg::*;

  logic  valid_bits [NUM_SETS];
  logic  dirty_bits [NUM_SETS];
  tag_t  tag_mem    [NUM_SETS];
  line_t data_mem   [NUM_SETS];

  // status bits cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_bits[s] <= 1'b0;
        dirty_bits[s] <= 1'b0;
      end
    end else if (we) begin
      valid_bits[idx] <= wr_line.valid;
      dirty_bits[idx] <= wr_line.dirty;
    end
  end

  // tag and line storage
  always_ff @(posedge clk) begin
    if (we) begin
      tag_mem[idx]  <= wr_line.tag;
      data_mem[idx] <= wr_line.data;
    end
  end

  // combinational read of the addressed set
  assign rd_line.valid = valid_bits[idx];
  assign rd_line.dirty = dirty_bits[idx];
  assign rd_line.tag   = tag_mem[idx];
  assign rd_line.data  = data_mem[idx];

  assign hit = valid_bits[idx] && (tag_mem[idx] == tag);

endmodule

//--- verilog/way_select.sv
`timescale 1ns/10ps

module way_select (
  input  logic                                            clk,
  input  logic                                            reset,
  input  cache_pkg::idx_t                                 idx,
  input  logic [cache_pkg::NUM_WAYS-1:0]                  way_hit,
  input  cache_pkg::way_line_t [cache_pkg::NUM_WAYS-1:0]  way_lines,
  input  logic                                            fill,
  output logic                                            hit,
  output cache_pkg::way_t                                 hit_way,
  output cache_pkg::way_line_t                            hit_line,
  output cache_pkg::way_t                                 victim_way,
  output cache_pkg::way_line_t                            victim_line
);

  import cache_pkg::*;

  // round-robin victim pointer per set
  way_t rr_ptr [NUM_SETS];

  // at most one way hits, so a plain scan is enough
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
    hit_line = way_lines[hit_way];
  end

  // lowest invalid way wins over the pointer
  always_comb begin
    victim_way = rr_ptr[idx];
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!way_lines[w].valid) begin
        victim_way = way_t'(w);
      end
    end
    victim_line = way_lines[victim_way];
  end

  // step only when the fill went into the pointed way
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_ptr[s] <= '0;
      end
    end else if (fill && (victim_way == rr_ptr[idx])) begin
      if (rr_ptr[idx] == way_t'(NUM_WAYS - 1)) begin
        rr_ptr[idx] <= '0;
      end else begin
        rr_ptr[idx] <= rr_ptr[idx] + 1'b1;
      end
    end
  end

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  cache_pkg::cpu_req_t           cpu_req,
  output cache_pkg::cpu_rsp_t           cpu_rsp,
  output cache_pkg::mem_req_t           mem_req,
  input  cache_pkg::mem_rsp_t           mem_rsp,
  output cache_pkg::idx_t               idx,
  output cache_pkg::tag_t               tag,
  output logic [cache_pkg::NUM_WAYS-1:0] way_we,
  output cache_pkg::way_line_t          wr_line,
  input  logic                          hit,
  input  cache_pkg::way_t               hit_way,
  input  cache_pkg::way_line_t          hit_line,
  input  cache_pkg::way_t               victim_way,
  input  cache_pkg::way_line_t          victim_line,
  output logic                          fill
);

  import cache_pkg::*;

  ctrl_state_t       state;
  ctrl_state_t       next_state;
  logic [OFF_W-1:0]  off;
  logic              accept;
  logic              missed;
  logic              ack_q;
  logic              hit_q;
  logic [WORD_W-1:0] dat_q;

  // the master holds the request until ack, so no address latch
  assign idx = cpu_req.adr[IDX_LSB +: IDX_W];
  assign tag = cpu_req.adr[TAG_LSB +: TAG_W];
  assign off = cpu_req.adr[OFF_LSB +: OFF_W];

  // strobe still held in the ack cycle is not a new request
  assign accept = cpu_req.cyc && cpu_req.stb && !ack_q;

  always_comb begin
    next_state = state;
    way_we     = '0;
    wr_line    = hit_line;
    fill       = 1'b0;
    mem_req    = '0;
    case (state)
      st_idle: begin
        if (accept) begin
          next_state = st_compare_tag;
        end
      end
      st_compare_tag: begin
        if (hit) begin
          next_state = st_idle;
          if (cpu_req.we) begin
            // merge the cpu word into the hit line
            way_we[hit_way]                     = 1'b1;
            wr_line.dirty                       = 1'b1;
            wr_line.data[off*WORD_W +: WORD_W] = cpu_req.dat;
          end
        end else if (victim_line.valid && victim_line.dirty) begin
          next_state = st_write_back;
        end else begin
          next_state = st_allocate;
        end
      end
      st_write_back: begin
        mem_req.cyc = 1'b1;
        mem_req.stb = 1'b1;
        mem_req.we  = 1'b1;
        mem_req.adr = {victim_line.tag, idx};
        mem_req.dat = victim_line.data;
        if (mem_rsp.ack) begin
          next_state = st_allocate;
        end
      end
      st_allocate: begin
        mem_req.cyc = 1'b1;
        mem_req.stb = 1'b1;
        mem_req.adr = {tag, idx};
        if (mem_rsp.ack) begin
          // install as valid and clean, then compare again
          way_we[victim_way] = 1'b1;
          wr_line.valid      = 1'b1;
          wr_line.dirty      = 1'b0;
          wr_line.tag        = tag;
          wr_line.data       = mem_rsp.dat;
          fill               = 1'b1;
          next_state         = st_compare_tag;
        end
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      ack_q  <= 1'b0;
      missed <= 1'b0;
    end else begin
      state <= next_state;
      ack_q <= (state == st_compare_tag) && hit;
      if (state == st_idle && accept) begin
        missed <= 1'b0;
      end else if (state == st_compare_tag && !hit) begin
        missed <= 1'b1;
      end
    end
  end

  // response word and first-compare result
  always_ff @(posedge clk) begin
    if (state == st_compare_tag && hit) begin
      hit_q <= !missed;
      dat_q <= hit_line.data[off*WORD_W +: WORD_W];
    end
  end

  assign cpu_rsp = {ack_q, hit_q, dat_q};

endmodule

//--- verilog/line_memory.sv
`timescale 1ns/10ps

module line_memory (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::mem_req_t mem_req,
  output cache_pkg::mem_rsp_t mem_rsp
);

  import cache_pkg::*;

  line_t                lines [MEM_LINES];
  logic [MEM_IDX_W-1:0] mem_idx;
  logic [LAT_W-1:0]     lat_cnt;
  logic                 req_live;
  logic                 last_cycle;
  logic                 ack_q;
  line_t                dat_q;

  // line address wraps modulo the memory size
  assign mem_idx = mem_req.adr[MEM_IDX_W-1:0];

  // a request held through its ack cycle is not counted again
  assign req_live   = mem_req.cyc && mem_req.stb && !ack_q;
  assign last_cycle = (lat_cnt == LAT_W'(MEM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      lat_cnt <= '0;
      ack_q   <= 1'b0;
      for (int i = 0; i < MEM_LINES; i++) begin
        lines[i] <= '0;
      end
    end else begin
      ack_q <= 1'b0;
      if (req_live) begin
        if (last_cycle) begin
          lat_cnt <= '0;
          ack_q   <= 1'b1;
        end else begin
          lat_cnt <= lat_cnt + 1'b1;
        end
      end
      // writes land in the ack cycle
      if (ack_q && mem_req.cyc && mem_req.stb && mem_req.we) begin
        lines[mem_idx] <= mem_req.dat;
      end
    end
  end

  // read data registered with the ack
  always_ff @(posedge clk) begin
    if (req_live && last_cycle) begin
      dat_q <= lines[mem_idx];
    end
  end

  assign mem_rsp = {ack_q, dat_q};

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/10ps

module cache_top (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::cpu_req_t cpu_req,
  output cache_pkg::cpu_rsp_t cpu_rsp
);

  import cache_pkg::*;

  idx_t                     idx;
  tag_t                     tag;
  logic [NUM_WAYS-1:0]      way_we;
  logic [NUM_WAYS-1:0]      way_hit;
  way_line_t                wr_line;
  way_line_t [NUM_WAYS-1:0] way_lines;
  logic                     hit;
  way_t                     hit_way;
  way_line_t                hit_line;
  way_t                     victim_way;
  way_line_t                victim_line;
  logic                     fill;
  mem_req_t                 mem_req;
  mem_rsp_t                 mem_rsp;

  cache_ctrl i_ctrl (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .cpu_rsp     (cpu_rsp),
    .mem_req     (mem_req),
    .mem_rsp     (mem_rsp),
    .idx         (idx),
    .tag         (tag),
    .way_we      (way_we),
    .wr_line     (wr_line),
    .hit         (hit),
    .hit_way     (hit_way),
    .hit_line    (hit_line),
    .victim_way  (victim_way),
    .victim_line (victim_line),
    .fill        (fill)
  );

  // identical ways all looking at the same set
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_way i_way (
      .clk     (clk),
      .reset   (reset),
      .idx     (idx),
      .tag     (tag),
      .we      (way_we[w]),
      .wr_line (wr_line),
      .rd_line (way_lines[w]),
      .hit     (way_hit[w])
    );
  end

  way_select i_sel (
    .clk         (clk),
    .reset       (reset),
    .idx         (idx),
    .way_hit     (way_hit),
    .way_lines   (way_lines),
    .fill        (fill),
    .hit         (hit),
    .hit_way     (hit_way),
    .hit_line    (hit_line),
    .victim_way  (victim_way),
    .victim_line (victim_line)
  );

  line_memory i_mem (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
  output logic clk,
  output logic reset
);

  localparam int HALF_NS      = 4;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // release just after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

//--- bench/tb_cache_top.sv
`timescale 1ns/10ps

module tb_cache_top;

  import cache_pkg::*;

  localparam int N_RANDOM    = 400;
  localparam int N_TX        = N_RANDOM + 12;
  // worst miss with write-back, plus hold, drop and longest gap
  localparam int TX_CYCLES   = 24;
  localparam int WATCHDOG_NS = (8 + N_TX * TX_CYCLES) * 8 + 1000;

  logic      clk;
  logic      reset;
  cpu_req_t  cpu_req;
  cpu_rsp_t  cpu_rsp;

  // reference model state
  logic [WORD_W-1:0] words [MEM_LINES*4];
  logic              model_valid [NUM_SETS][NUM_WAYS];
  tag_t              model_tag [NUM_SETS][NUM_WAYS];
  way_t              model_rr [NUM_SETS];
  logic [15:0]       lfsr = 16'd4636;

  clock_gen i_clk (
    .clk   (clk),
    .reset (reset)
  );

  cache_top i_dut (
    .clk     (clk),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp)
  );

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // returns the expected hit flag and installs the line on a miss
  function automatic logic model_lookup(input logic [31:0] adr);
    idx_t s;
    tag_t tg;
    way_t victim;
    logic found;
    s     = adr[7:4];
    tg    = adr[31:8];
    found = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (model_valid[s][w] && model_tag[s][w] == tg) begin
        return 1'b1;
      end
    end
    victim = model_rr[s];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && !model_valid[s][w]) begin
        victim = way_t'(w);
        found  = 1'b1;
      end
    end
    if (victim == model_rr[s]) begin
      model_rr[s] = way_t'((int'(model_rr[s]) + 1) % NUM_WAYS);
    end
    model_valid[s][victim] = 1'b1;
    model_tag[s][victim]   = tg;
    return 1'b0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      check_value("cpu_rsp.ack", 32'd0, 32'(cpu_rsp.ack));
    end
  endtask

  // one wishbone classic access started 1 ns after a rising edge
  task automatic do_access(input logic wr, input logic [31:0] adr, input logic [31:0] dat);
    logic        exp_hit;
    logic [31:0] exp_dat;
    int          cycles;
    exp_hit = model_lookup(adr);
    exp_dat = words[adr[11:2]];
    if (wr) begin
      words[adr[11:2]] = dat;
    end
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;
    cpu_req.we  = wr;
    cpu_req.adr = adr;
    cpu_req.dat = dat;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!cpu_rsp.ack);
    check_value("cpu_rsp.hit", 32'(exp_hit), 32'(cpu_rsp.hit));
    if (exp_hit) begin
      check_value("hit ack latency", 32'd2, 32'(cycles));
    end
    if (!wr) begin
      check_value("cpu_rsp.dat", exp_dat, cpu_rsp.dat);
    end
    // strobe was still up at this edge yet ack is gone
    @(posedge clk);
    #1;
    check_value("cpu_rsp.ack", 32'd0, 32'(cpu_rsp.ack));
    // address stays on the bus so a re-accepted strobe would hit and ack again
    cpu_req.cyc = 1'b0;
    cpu_req.stb = 1'b0;
    idle_cycles(1);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired: the cache stopped answering the CPU");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] d;
    logic [31:0] g;
    cpu_req = '0;
    for (int i = 0; i < MEM_LINES * 4; i++) begin
      words[i] = '0;
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      model_rr[s] = '0;
      for (int k = 0; k < NUM_WAYS; k++) begin
        model_valid[s][k] = 1'b0;
        model_tag[s][k]   = '0;
      end
    end
    wait (!reset);
    idle_cycles(4);

    // never written so it reads zero as a miss
    do_access(1'b0, 32'h0000_0340, 32'd0);
    do_access(1'b1, 32'h0000_0124, 32'hA5A5_1234);
    do_access(1'b0, 32'h0000_0124, 32'd0);

    // three tags fighting over set 9
    for (int t = 1; t <= 3; t++) begin
      do_access(1'b1, {20'd0, 4'(t), 4'h9, 2'(t), 2'b00}, 32'h1111_0000 + 32'(t));
    end
    for (int k = 0; k < 6; k++) begin
      do_access(1'b0, {20'd0, 4'(k % 3 + 1), 4'h9, 2'(k % 3 + 1), 2'b00}, 32'd0);
    end

    // small pool of sets and tags keeps conflicts frequent
    for (int n = 0; n < N_RANDOM; n++) begin
      r = rand_bits(6);
      w = rand_bits(1);
      d = rand_bits(32);
      g = rand_bits(2);
      do_access(w[0], {20'd0, 2'b00, r[5:4], 2'b00, r[3:2], r[1:0], 2'b00}, d);
      idle_cycles(int'(g[1:0]));
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- cache_top.f
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/way_select.sv
verilog/cache_ctrl.sv
verilog/line_memory.sv
verilog/cache_top.sv
bench/clock_gen.sv
bench/tb_cache_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cache_top -f cache_top.f -o sim_cache_top
./obj_dir/sim_cache_top 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run_sim.sh: simulation reported failure"
  exit 1
fi
echo "run_sim.sh: simulation passed"
